// File: common/lc3b_types.sv
`default_nettype none

package lc3b_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] lc3b_word;
    typedef logic [1:0]  lc3b_mem_wmask;    // Bit 0 is the low byte

    localparam int LINE_OFFSET_BITS = 4;   // 16-byte line

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache line and CPU request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Read as eight words, written by byte merge
    typedef union packed {
        lc3b_word [7:0]        words;
        logic     [15:0][7:0]  bytes;
    } lc3b_line;

    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_word      address;
        lc3b_word      wdata;
        lc3b_mem_wmask byte_enable;
    } lc3b_cpu_req;

    typedef enum logic [1:0] {
        CHECK,
        WRITEBACK,
        FILL
    } cache_state_e;

endpackage : lc3b_types

`default_nettype wire

// File: d_cache/d_cache_datapath.sv
`default_nettype none

module d_cache_datapath
    import lc3b_types::*;
#(
    parameter int INDEX_BITS = 3
)
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  lc3b_cpu_req cpu_req,
    input  wire logic   load_hit,
    input  wire logic   load_fill,
    input  lc3b_line    pmem_rdata,
    output logic        hit,
    output logic        hit_way,
    output logic        lru_way,
    output logic        victim_dirty,
    output logic [15-LINE_OFFSET_BITS-INDEX_BITS:0] victim_tag,
    output lc3b_word    mem_rdata,
    output lc3b_line    pmem_wdata
);

    localparam int TAG_BITS = 16 - LINE_OFFSET_BITS - INDEX_BITS;
    localparam int SETS     = 1 << INDEX_BITS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [TAG_BITS-1:0]   tag_q  [2][SETS];
    lc3b_line              data_q [2][SETS];
    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]       lru_q;              // Way to replace next

    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] index;
    logic [2:0]            word_off;
    logic                  hit0;
    logic                  hit1;
    lc3b_line              hit_line;
    lc3b_line              merged_line;

    assign req_tag  = cpu_req.address[15 -: TAG_BITS];
    assign index    = cpu_req.address[LINE_OFFSET_BITS +: INDEX_BITS];
    assign word_off = cpu_req.address[LINE_OFFSET_BITS-1:1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hit0    = valid_q[0][index] && (tag_q[0][index] == req_tag);
    assign hit1    = valid_q[1][index] && (tag_q[1][index] == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    assign lru_way      = lru_q[index];
    assign victim_dirty = dirty_q[lru_way][index];
    assign victim_tag   = tag_q[lru_way][index];
    assign pmem_wdata   = data_q[lru_way][index];

    assign hit_line  = data_q[hit_way][index];
    assign mem_rdata = hit_line.words[word_off];

    // Byte merge of the CPU write into the hit line
    always_comb
    begin
        merged_line = hit_line;
        if (cpu_req.byte_enable[0])
            merged_line.bytes[{word_off, 1'b0}] = cpu_req.wdata[7:0];
        if (cpu_req.byte_enable[1])
            merged_line.bytes[{word_off, 1'b1}] = cpu_req.wdata[15:8];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (load_fill)
        begin
            data_q[lru_way][index] <= pmem_rdata;
            tag_q[lru_way][index]  <= req_tag;
        end
        else if (load_hit && cpu_req.write)
        begin
            data_q[hit_way][index] <= merged_line;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end
        else if (load_fill)
        begin
            valid_q[lru_way][index] <= 1'b1;
            dirty_q[lru_way][index] <= 1'b0;    // Fresh line from memory
            lru_q[index]            <= ~lru_way;
        end
        else if (load_hit)
        begin
            lru_q[index] <= ~hit_way;
            if (cpu_req.write)
                dirty_q[hit_way][index] <= 1'b1;
        end
    end

    // A fill never duplicates a line that is already present in the set
    assert property (@(posedge clk) disable iff (!rst_n) !(hit0 && hit1));

endmodule : d_cache_datapath

`default_nettype wire

// File: d_cache/d_cache_control.sv
`default_nettype none

module d_cache_control
    import lc3b_types::*;
#(
    parameter int INDEX_BITS = 3
)
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  lc3b_cpu_req cpu_req,
    input  wire logic   hit,
    input  wire logic   lru_way,
    input  wire logic   victim_dirty,
    input  wire logic [15-LINE_OFFSET_BITS-INDEX_BITS:0] victim_tag,
    input  wire logic   pmem_resp,
    output logic        load_hit,
    output logic        load_fill,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    output lc3b_word    pmem_address
);

    localparam int TAG_BITS = 16 - LINE_OFFSET_BITS - INDEX_BITS;

    cache_state_e          state_q;
    cache_state_e          state_d;
    logic                  req_active;
    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] index;
    lc3b_word              victim_addr;
    lc3b_word              fill_addr;

    assign req_active = cpu_req.read || cpu_req.write;
    assign req_tag    = cpu_req.address[15 -: TAG_BITS];
    assign index      = cpu_req.address[LINE_OFFSET_BITS +: INDEX_BITS];

    // Line aligned addresses for the two memory transfers
    assign victim_addr = {victim_tag, index, {LINE_OFFSET_BITS{1'b0}}};
    assign fill_addr   = {req_tag, index, {LINE_OFFSET_BITS{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= CHECK;
        else
            state_q <= state_d;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        state_d      = state_q;
        load_hit     = 1'b0;
        load_fill    = 1'b0;
        mem_resp     = 1'b0;
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        pmem_address = fill_addr;

        unique case (state_q)
            CHECK:
            begin
                if (req_active && hit)
                begin
                    mem_resp = 1'b1;            // Single-cycle hit
                    load_hit = 1'b1;
                end
                else if (req_active)
                begin
                    state_d = victim_dirty ? WRITEBACK : FILL;
                end
            end

            WRITEBACK:
            begin
                pmem_write   = 1'b1;
                pmem_address = victim_addr;     // Old line of the LRU way
                if (pmem_resp)
                    state_d = FILL;
            end

            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    load_fill = 1'b1;           // Into the LRU way
                    state_d   = CHECK;
                end
            end

            default:
            begin
                state_d = CHECK;
            end
        endcase
    end

    // Victim way stays fixed while the miss is being serviced
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == WRITEBACK) && !pmem_resp |=> $stable(lru_way));

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |-> (cpu_req.read || cpu_req.write));

endmodule : d_cache_control

`default_nettype wire

// File: d_cache/d_cache.sv
`default_nettype none

module d_cache
    import lc3b_types::*;
#(
    parameter int INDEX_BITS = 3
)
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  lc3b_cpu_req cpu_req,
    input  wire logic   pmem_resp,
    input  lc3b_line    pmem_rdata,
    output logic        mem_resp,
    output lc3b_word    mem_rdata,
    output logic        pmem_read,
    output logic        pmem_write,
    output lc3b_word    pmem_address,
    output lc3b_line    pmem_wdata,
    output lc3b_word    l1_miss_counter
);

    localparam int TAG_BITS = 16 - LINE_OFFSET_BITS - INDEX_BITS;

    logic                hit;
    logic                lru_way;
    logic                victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    logic                load_hit;
    logic                load_fill;

    // Line fills since reset, wraps at 16 bits
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            l1_miss_counter <= '0;
        else if (pmem_read && pmem_resp)
            l1_miss_counter <= l1_miss_counter + 16'd1;
    end

    d_cache_datapath #(
        .INDEX_BITS (INDEX_BITS)
    ) datapath0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .load_hit     (load_hit),
        .load_fill    (load_fill),
        .pmem_rdata   (pmem_rdata),
        .hit          (hit),
        .hit_way      (),
        .lru_way      (lru_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mem_rdata    (mem_rdata),
        .pmem_wdata   (pmem_wdata)
    );

    d_cache_control #(
        .INDEX_BITS (INDEX_BITS)
    ) control0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .lru_way      (lru_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .pmem_resp    (pmem_resp),
        .load_hit     (load_hit),
        .load_fill    (load_fill),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address)
    );

    // Memory port carries one request kind at a time
    assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write));

endmodule : d_cache

`default_nettype wire

// File: tests/pmem_model.sv
`default_nettype none

module pmem_model
    import lc3b_types::*;
#(
    parameter int LATENCY = 3
)
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic pmem_read,
    input  wire logic pmem_write,
    input  lc3b_word  pmem_address,
    input  lc3b_line  pmem_wdata,
    output lc3b_line  pmem_rdata,
    output logic      pmem_resp
);

    lc3b_line mem [4096];                   // 64 KB as 16-byte lines
    int       wait_cycles;

    // Word at word address a holds a xor 5a5a
    initial
    begin
        for (int l = 0; l < 4096; l++)
            for (int k = 0; k < 8; k++)
                mem[12'(l)].words[3'(k)] = {1'b0, 12'(l), 3'(k)} ^ 16'h5a5a;
    end

    assign pmem_rdata = mem[pmem_address[15:4]];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pmem_resp   <= 1'b0;
            wait_cycles <= 0;
        end
        else if (pmem_resp)
        begin
            pmem_resp   <= 1'b0;            // One-cycle response
            wait_cycles <= 0;
        end
        else if (pmem_read || pmem_write)
        begin
            if (wait_cycles == LATENCY - 1)
                pmem_resp <= 1'b1;
            else
                wait_cycles <= wait_cycles + 1;
        end
    end

    always @(posedge clk)
    begin
        if (pmem_write && pmem_resp)
            mem[pmem_address[15:4]] <= pmem_wdata;
    end

endmodule : pmem_model

`default_nettype wire

// File: tests/tb_d_cache.sv
`default_nettype none

module tb_d_cache
    import lc3b_types::*;
();

    logic        clk;
    logic        rst_n;
    lc3b_cpu_req cpu_req;
    logic        mem_resp;
    lc3b_word    mem_rdata;
    logic        pmem_read;
    logic        pmem_write;
    logic        pmem_resp;
    lc3b_word    pmem_address;
    lc3b_word    l1_miss_counter;
    lc3b_line    pmem_wdata;
    lc3b_line    pmem_rdata;

    logic [7:0]  shadow [65536];           // Byte-wise image of memory as the CPU sees it

    d_cache #(
        .INDEX_BITS (3)
    ) dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req         (cpu_req),
        .pmem_resp       (pmem_resp),
        .pmem_rdata      (pmem_rdata),
        .mem_resp        (mem_resp),
        .mem_rdata       (mem_rdata),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .l1_miss_counter (l1_miss_counter)
    );

    pmem_model #(
        .LATENCY (3)
    ) mem0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input lc3b_word expected,
                               input lc3b_word actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED at time %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    endtask

    // Word at word address a holds a xor 5a5a
    task automatic init_shadow();
        lc3b_word baddr;
        lc3b_word w;
        for (int i = 0; i < 65536; i++)
        begin
            baddr         = 16'(i);
            w             = {1'b0, baddr[15:1]} ^ 16'h5a5a;
            shadow[baddr] = baddr[0] ? w[15:8] : w[7:0];
        end
    endtask

    function automatic lc3b_word shadow_word(input lc3b_word addr);
        return {shadow[{addr[15:1], 1'b1}], shadow[{addr[15:1], 1'b0}]};
    endfunction

    task automatic write_shadow(input lc3b_word addr, input lc3b_mem_wmask mask,
                                input lc3b_word data);
        if (mask[0])
            shadow[{addr[15:1], 1'b0}] = data[7:0];
        if (mask[1])
            shadow[{addr[15:1], 1'b1}] = data[15:8];
    endtask

    // Starts just after a rising edge and returns just after the edge that ends the access
    task automatic run_access(input logic is_write, input lc3b_word addr,
                              input lc3b_mem_wmask mask, input lc3b_word data,
                              output lc3b_word rdata);
        int cycles;
        cycles              = 0;
        cpu_req.read        = !is_write;
        cpu_req.write       = is_write;
        cpu_req.address     = addr;
        cpu_req.wdata       = data;
        cpu_req.byte_enable = mask;
        @(negedge clk);
        while (!mem_resp)
        begin
            cycles++;
            if (cycles >= 200)
                abort_run($sformatf("no mem_resp within 200 cycles for address %h", addr));
            @(negedge clk);
        end
        rdata = mem_rdata;
        @(posedge clk);
        #1;
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        int            fd;
        int            n;
        string         line;
        logic [7:0]    op;
        lc3b_word      addr;
        lc3b_mem_wmask mask;
        lc3b_word      data;
        lc3b_word      count;
        lc3b_word      rdata;

        clk     = 1'b0;
        rst_n   = 1'b0;
        cpu_req = '0;
        init_shadow();
        fd = $fopen("tests/d_cache_stim.txt", "r");
        if (fd == 0)
            abort_run("could not open the stimulus file tests/d_cache_stim.txt");

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);                     // Idle outputs after reset
        check_value("mem_resp", 16'h0000, 16'(mem_resp));
        check_value("pmem_read", 16'h0000, 16'(pmem_read));
        check_value("pmem_write", 16'h0000, 16'(pmem_write));
        check_value("l1_miss_counter", 16'h0000, l1_miss_counter);
        @(posedge clk);
        #1;

        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%c %h %h %h %h", op, addr, mask, data, count);
            if (n != 5)
                abort_run($sformatf("malformed line in stimulus file: %s", line));
            case (op)
                "R":
                begin
                    run_access(1'b0, addr, mask, data, rdata);
                    check_value("mem_rdata", shadow_word(addr), rdata);
                end
                "W":
                begin
                    run_access(1'b1, addr, mask, data, rdata);
                    write_shadow(addr, mask, data);
                end
                "C":
                begin
                    @(negedge clk);
                    check_value("l1_miss_counter", count, l1_miss_counter);
                    @(posedge clk);
                    #1;
                end
                default:
                    abort_run($sformatf("unknown operation code in stimulus file: %s", line));
            endcase
        end
        $fclose(fd);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_d_cache

`default_nettype wire

// File: tests/d_cache_stim.txt
# op addr mask wdata count   (op R read, W write, C miss count check)
# mask and wdata matter for W only, count for C only, all values hex
C 0000 0 0000 0000
R 0100 0 0000 0000
R 0102 0 0000 0000
C 0000 0 0000 0001
W 0104 1 a1b2 0000
W 0106 2 c3d4 0000
W 0108 3 e5f6 0000
R 0104 0 0000 0000
R 0106 0 0000 0000
R 0108 0 0000 0000
R 010e 0 0000 0000
C 0000 0 0000 0001
W 0020 3 1234 0000
R 00a0 0 0000 0000
R 0120 0 0000 0000
C 0000 0 0000 0004
R 0020 0 0000 0000
R 0022 0 0000 0000
C 0000 0 0000 0005
R 0180 0 0000 0000
R 0200 0 0000 0000
R 0104 0 0000 0000
R 0106 0 0000 0000
R 0108 0 0000 0000
C 0000 0 0000 0008
W 0336 2 9900 0000
R 0336 0 0000 0000
R 0334 0 0000 0000
R fffe 0 0000 0000
C 0000 0 0000 000a

// File: d_cache.f
common/lc3b_types.sv
d_cache/d_cache_datapath.sv
d_cache/d_cache_control.sv
d_cache/d_cache.sv
tests/pmem_model.sv
tests/tb_d_cache.sv

// File: Makefile
SIM  := obj_dir/Vtb_d_cache
SRCS := $(shell cat d_cache.f)

.PHONY: all run clean

all: run

$(SIM): d_cache.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_d_cache -f d_cache.f

run: $(SIM) tests/d_cache_stim.txt
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "run did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
